//--- rtl/matrix_root_macros.svh
/*
  Sizing constants shared by RTL and testbench
  Data width, matrix size and FIFO depth are fixed at build time
*/
`ifndef MATRIX_ROOT_MACROS_SVH
`define MATRIX_ROOT_MACROS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Operand A, modulus and result
`define MR_DATA_W 16
// Exponent field, a value of 0 acts as 1
`define MR_EXP_W 4
// Row or column index
`define MR_IDX_W 3

//////////////////////////////////////////////////
// Sizes
//////////////////////////////////////////////////

// Largest row or column count
`define MR_MAX_DIM 8
// Entries in the job FIFO
`define MR_FIFO_DEPTH 4

`endif

//--- rtl/matrix_root_pkg.sv
/*
  Packed types for the matrix root datapath
  Row and column counts in a command must be 1 to MR_MAX_DIM
*/
`include "matrix_root_macros.svh"

package matrix_root_pkg;

  // Job start command
  typedef struct packed {
    logic [$clog2(`MR_MAX_DIM):0] rows;
    logic [$clog2(`MR_MAX_DIM):0] cols;
    logic [`MR_DATA_W-1:0]        modulus;
  } mr_cmd_t;

  // One matrix element, root of a with degree b
  typedef struct packed {
    logic [`MR_DATA_W-1:0] a;
    logic [`MR_EXP_W-1:0]  b;
  } mr_elem_t;

  // Tagged entry in the job FIFO
  typedef struct packed {
    mr_elem_t              elem;
    logic [`MR_DATA_W-1:0] modulus;
    logic [`MR_IDX_W-1:0]  row;
    logic [`MR_IDX_W-1:0]  col;
    logic                  last;
  } mr_job_t;

  // Tagged result
  typedef struct packed {
    logic [`MR_DATA_W-1:0] value;
    logic [`MR_IDX_W-1:0]  row;
    logic [`MR_IDX_W-1:0]  col;
    logic                  last;
  } mr_result_t;

  // Sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_WAIT_REQ,
    SEQ_ACK_HIGH,
    SEQ_WAIT_REL
  } seq_state_e;

  // Root engine FSM
  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_TRIAL,
    ENG_POWER,
    ENG_REDUCE,
    ENG_SEND,
    ENG_WAIT_REL
  } eng_state_e;

endpackage

//--- rtl/element_sequencer.sv
/*
  Takes one job per start, rows and cols of 0 are not supported
  Start is ignored while busy; elements wait while the FIFO is full
*/
`include "matrix_root_macros.svh"

module element_sequencer
  import matrix_root_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     start,
  input  mr_cmd_t  cmd,
  input  logic     elem_req,
  input  mr_elem_t elem,
  output logic     elem_ack,
  output logic     busy,
  output logic     push_valid,
  output mr_job_t  push_job,
  input  logic     push_ready
);

  seq_state_e           state;
  mr_cmd_t              cmd_q;
  logic [`MR_IDX_W-1:0] row;
  logic [`MR_IDX_W-1:0] col;
  logic                 row_end;
  logic                 col_end;
  logic                 last;

  //////////////////////////////////////////////////
  // Position in the matrix
  //////////////////////////////////////////////////

  // Counts are 1-based, indices 0-based
  assign row_end = ({1'b0, row} == cmd_q.rows - 1'b1);
  assign col_end = ({1'b0, col} == cmd_q.cols - 1'b1);
  assign last    = row_end && col_end;

  //////////////////////////////////////////////////
  // Handshake outputs
  //////////////////////////////////////////////////

  // Ack is a pure state decode, high for the whole ack phase
  assign elem_ack   = (state == SEQ_ACK_HIGH);
  // Busy ends on the same edge as the last ack
  assign busy       = (state != SEQ_IDLE);
  // Offer the element as soon as req is seen
  assign push_valid = (state == SEQ_WAIT_REQ) && elem_req;

  // Tagged job, elem is held stable by the source while req is high
  always_comb begin
    push_job.elem    = elem;
    push_job.modulus = cmd_q.modulus;
    push_job.row     = row;
    push_job.col     = col;
    push_job.last    = last;
  end

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= SEQ_IDLE;
      row   <= '0;
      col   <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            row   <= '0;
            col   <= '0;
            state <= SEQ_WAIT_REQ;
          end
        end
        SEQ_WAIT_REQ: begin
          // Push and ack happen together
          if (push_valid && push_ready) begin
            state <= SEQ_ACK_HIGH;
          end
        end
        SEQ_ACK_HIGH: begin
          // Source released req, drop ack
          if (!elem_req) begin
            state <= last ? SEQ_IDLE : SEQ_WAIT_REL;
          end
        end
        SEQ_WAIT_REL: begin
          // Advance in row-major order
          if (col_end) begin
            col <= '0;
            row <= row + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
          state <= SEQ_WAIT_REQ;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Command held for the whole matrix
  always_ff @(posedge CLK) begin
    if (state == SEQ_IDLE && start) begin
      cmd_q <= cmd;
    end
  end

endmodule

//--- rtl/job_fifo.sv
/*
  Registered-output FIFO, a push shows at the head one cycle later
  Push and pop may happen in the same cycle
*/
`include "matrix_root_macros.svh"

module job_fifo
  import matrix_root_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    push_valid,
  input  mr_job_t push_job,
  output logic    push_ready,
  output logic    pop_valid,
  output mr_job_t pop_job,
  input  logic    pop_ready
);

  localparam int PTR_W = $clog2(`MR_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`MR_FIFO_DEPTH + 1);

  mr_job_t            mem [`MR_FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push_fire;
  logic               pop_fire;

  // Full and empty flags
  assign push_ready = (count != CNT_W'(`MR_FIFO_DEPTH));
  assign pop_valid  = (count != '0);
  assign pop_job    = mem[rd_ptr];

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(`MR_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(`MR_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_job;
    end
  end

endmodule

//--- rtl/root_engine.sv
/*
  One job at a time, 16 trial bits, each up to b-1 multiplies plus a compare
  Exponent 0 acts as 1; modulus 0 returns the root unreduced
*/
`include "matrix_root_macros.svh"

module root_engine
  import matrix_root_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       pop_valid,
  input  mr_job_t    pop_job,
  output logic       pop_ready,
  output logic       res_req,
  output mr_result_t res,
  input  logic       res_ack
);

  localparam int BIT_W = $clog2(`MR_DATA_W);
  localparam logic [BIT_W-1:0]      TOP_BIT  = BIT_W'(`MR_DATA_W - 1);
  localparam logic [`MR_DATA_W-1:0] DATA_ONE = 1;
  localparam logic [`MR_EXP_W-1:0]  EXP_ONE  = 1;

  eng_state_e              state;
  mr_job_t                 job_q;
  logic [`MR_DATA_W-1:0]   root;
  logic [`MR_DATA_W-1:0]   cand;
  logic [`MR_DATA_W-1:0]   prod;
  logic [`MR_DATA_W-1:0]   trial;
  logic [2*`MR_DATA_W-1:0] prod_full;
  logic [BIT_W-1:0]        bit_idx;
  logic [`MR_EXP_W-1:0]    mults_left;
  logic [`MR_EXP_W-1:0]    exp_eff;
  logic                    over;
  logic                    power_done;

  assign pop_ready = (state == ENG_IDLE);
  assign res_req   = (state == ENG_SEND);

  //////////////////////////////////////////////////
  // Trial arithmetic
  //////////////////////////////////////////////////

  assign exp_eff    = (job_q.elem.b == '0) ? EXP_ONE : job_q.elem.b;
  // Candidate root with the current bit set
  assign trial      = root | (DATA_ONE << bit_idx);
  // Both factors stay at or below A, so no overflow in 32 bits
  assign prod_full  = prod * cand;
  // Stop early once the power is known to pass A
  assign power_done = (mults_left == '0) || over;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ENG_IDLE;
      bit_idx    <= '0;
      mults_left <= '0;
      over       <= 1'b0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (pop_valid) begin
            bit_idx <= TOP_BIT;
            state   <= ENG_TRIAL;
          end
        end
        ENG_TRIAL: begin
          // First power is the candidate itself
          over       <= (trial > job_q.elem.a);
          mults_left <= exp_eff - 1'b1;
          state      <= ENG_POWER;
        end
        ENG_POWER: begin
          if (!power_done) begin
            over       <= (prod_full > {{`MR_DATA_W{1'b0}}, job_q.elem.a});
            mults_left <= mults_left - 1'b1;
          end else if (bit_idx == '0) begin
            state <= ENG_REDUCE;
          end else begin
            bit_idx <= bit_idx - 1'b1;
            state   <= ENG_TRIAL;
          end
        end
        ENG_REDUCE: state <= ENG_SEND;
        ENG_SEND: begin
          if (res_ack) begin
            state <= ENG_WAIT_REL;
          end
        end
        ENG_WAIT_REL: begin
          // Sink must release ack before the next pop
          if (!res_ack) begin
            state <= ENG_IDLE;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      ENG_IDLE: begin
        if (pop_valid) begin
          job_q <= pop_job;
          root  <= '0;
        end
      end
      ENG_TRIAL: begin
        cand <= trial;
        prod <= trial;
      end
      ENG_POWER: begin
        if (!power_done) begin
          prod <= prod_full[`MR_DATA_W-1:0];
        end else if (!over) begin
          // Power fits under A, keep the bit
          root <= cand;
        end
      end
      ENG_REDUCE: begin
        res.value <= (job_q.modulus != '0) ? root % job_q.modulus : root;
        res.row   <= job_q.row;
        res.col   <= job_q.col;
        res.last  <= job_q.last;
      end
      default: ;
    endcase
  end

endmodule

//--- rtl/matrix_root_top.sv
/*
  Element-wise modular integer root over a matrix of up to 8 by 8
  Results leave in input order over a four-phase req/ack port
*/
module matrix_root_top
  import matrix_root_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       start,
  input  mr_cmd_t    cmd,
  output logic       busy,
  input  logic       elem_req,
  input  mr_elem_t   elem,
  output logic       elem_ack,
  output logic       res_req,
  output mr_result_t res,
  input  logic       res_ack
);

  // Sequencer to FIFO
  logic    push_valid;
  logic    push_ready;
  mr_job_t push_job;
  // FIFO to engine
  logic    pop_valid;
  logic    pop_ready;
  mr_job_t pop_job;

  // Producer, tags incoming elements
  element_sequencer u_sequencer (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .cmd        (cmd),
    .elem_req   (elem_req),
    .elem       (elem),
    .elem_ack   (elem_ack),
    .busy       (busy),
    .push_valid (push_valid),
    .push_job   (push_job),
    .push_ready (push_ready)
  );

  // Buffer between producer and consumer
  job_fifo u_fifo (
    .CLK        (CLK),
    .RST        (RST),
    .push_valid (push_valid),
    .push_job   (push_job),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_job    (pop_job),
    .pop_ready  (pop_ready)
  );

  // Consumer
  root_engine u_engine (
    .CLK       (CLK),
    .RST       (RST),
    .pop_valid (pop_valid),
    .pop_job   (pop_job),
    .pop_ready (pop_ready),
    .res_req   (res_req),
    .res       (res),
    .res_ack   (res_ack)
  );

endmodule

//--- tb/matrix_root_sva.sv
/*
  Handshake and reset checks on the ports of matrix_root_top
  Sampled on CLK, both four-phase ports are checked from the DUT side
*/
module matrix_root_sva
  import matrix_root_pkg::*;
(
  input logic       CLK,
  input logic       RST,
  input logic       busy,
  input logic       elem_req,
  input logic       elem_ack,
  input logic       res_req,
  input mr_result_t res,
  input logic       res_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_errors = 0;

  //////////////////////////////////////////////////
  // Result port
  //////////////////////////////////////////////////

  // Data held while waiting for ack
  res_stable_a: assert property (
    @(posedge CLK) disable iff (RST) (res_req && !res_ack) |=> $stable(res)
  ) else begin
    assert_errors++;
    $error("res changed while res_req waited for res_ack");
  end

  // No early withdrawal of the request
  res_req_hold_a: assert property (
    @(posedge CLK) disable iff (RST) (res_req && !res_ack) |=> res_req
  ) else begin
    assert_errors++;
    $error("res_req fell before res_ack rose");
  end

  //////////////////////////////////////////////////
  // Element port
  //////////////////////////////////////////////////

  elem_ack_rise_a: assert property (
    @(posedge CLK) disable iff (RST) $rose(elem_ack) |-> elem_req
  ) else begin
    assert_errors++;
    $error("elem_ack rose without elem_req");
  end

  // Quiet outputs in reset
  reset_values_a: assert property (
    @(posedge CLK) RST |-> (!res_req && !elem_ack && !busy)
  ) else begin
    assert_errors++;
    $error("res_req, elem_ack or busy high during reset");
  end

endmodule

//--- tb/matrix_root_tb.sv
/*
  Fixed table of jobs plus one LCG matrix, sink delays res_ack by 0 to 20 cycles
  Job 1 carries a second start while busy, which must be ignored
*/
`include "matrix_root_macros.svh"

module matrix_root_tb
  import matrix_root_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TBL_JOBS    = 4;
  localparam int TBL_ELEMS   = 24;
  localparam int IGNORED_JOB = 1;
  localparam mr_cmd_t IGNORED_CMD = '{4'd1, 4'd1, 16'd10};

  logic       CLK;
  logic       RST;
  logic       start;
  mr_cmd_t    cmd;
  logic       busy;
  logic       elem_req;
  mr_elem_t   elem;
  logic       elem_ack;
  logic       res_req;
  mr_result_t res;
  logic       res_ack;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  // Rows, cols, modulus
  mr_cmd_t tbl_cmd [TBL_JOBS] = '{
    '{4'd2, 4'd2, 16'd0}, '{4'd2, 4'd2, 16'd7}, '{4'd2, 4'd2, 16'd10}, '{4'd3, 4'd4, 16'd0}
  };
  mr_elem_t tbl_elem [TBL_ELEMS] = '{
    // Plain roots, then the same with modulus 7
    '{16'd144, 4'd2}, '{16'd27, 4'd3}, '{16'd26, 4'd3}, '{16'd65535, 4'd2},
    '{16'd144, 4'd2}, '{16'd27, 4'd3}, '{16'd26, 4'd3}, '{16'd65535, 4'd2},
    // Modulus 10, exponent 0 acts as 1
    '{16'd144, 4'd2}, '{16'd65535, 4'd2}, '{16'd1234, 4'd0}, '{16'd1000, 4'd3},
    // 3 by 4 ordering job, values on both sides of a floor
    '{16'd0, 4'd2}, '{16'd1, 4'd5}, '{16'd15, 4'd2}, '{16'd16, 4'd2},
    '{16'd17, 4'd4}, '{16'd80, 4'd4}, '{16'd81, 4'd4}, '{16'd65535, 4'd15},
    '{16'd1023, 4'd10}, '{16'd1024, 4'd10}, '{16'd999, 4'd3}, '{16'd50000, 4'd1}
  };
  logic [`MR_DATA_W-1:0] tbl_exp [TBL_ELEMS] = '{
    16'd12, 16'd3, 16'd2, 16'd255, 16'd5, 16'd3, 16'd2, 16'd3,
    16'd2, 16'd5, 16'd4, 16'd0, 16'd0, 16'd1, 16'd3, 16'd4,
    16'd2, 16'd2, 16'd3, 16'd2, 16'd1, 16'd2, 16'd9, 16'd50000
  };

  // Flat job list, table first, random job last
  mr_cmd_t               job_cmd  [$];
  mr_elem_t              elem_in  [$];
  logic [`MR_DATA_W-1:0] elem_exp [$];
  // Results still owed by the DUT, oldest first
  mr_result_t            exp_q    [$];

  int unsigned lcg_state   = 23;
  int          cycles      = 0;
  int          cycle_limit = 0;

  matrix_root_top i_dut (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .cmd      (cmd),
    .busy     (busy),
    .elem_req (elem_req),
    .elem     (elem),
    .elem_ack (elem_ack),
    .res_req  (res_req),
    .res      (res),
    .res_ack  (res_ack)
  );

  bind matrix_root_top matrix_root_sva i_sva (
    .CLK      (CLK),
    .RST      (RST),
    .busy     (busy),
    .elem_req (elem_req),
    .elem_ack (elem_ack),
    .res_req  (res_req),
    .res      (res),
    .res_ack  (res_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // Low bits of an LCG are weak
    return lcg_state >> 8;
  endfunction

  // r to the power n, clipped one above the data range
  function automatic longint unsigned pow_capped(int unsigned r, int unsigned n);
    longint unsigned p;
    p = 1;
    for (int unsigned i = 0; i < n; i++) begin
      p = p * r;
      if (p > (64'd1 << `MR_DATA_W)) begin
        p = 64'd1 << `MR_DATA_W;
      end
    end
    return p;
  endfunction

  // Largest r with r**b <= a by binary search, then mod m
  function automatic logic [`MR_DATA_W-1:0] root_ref(mr_elem_t e, logic [`MR_DATA_W-1:0] m);
    int unsigned n;
    int unsigned lo;
    int unsigned hi;
    int unsigned mid;
    n  = (e.b == '0) ? 1 : 32'(e.b);
    lo = 0;
    hi = 32'(e.a);
    while (lo < hi) begin
      mid = (lo + hi + 1) / 2;
      if (pow_capped(mid, n) <= 64'(e.a)) begin
        lo = mid;
      end else begin
        hi = mid - 1;
      end
    end
    if (m != '0) begin
      lo = lo % 32'(m);
    end
    return `MR_DATA_W'(lo);
  endfunction

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
      stop_with_failure();
    end
  endtask

  task automatic build_jobs();
    mr_cmd_t  c;
    mr_elem_t e;
    int       j;
    int       n;
    int       k;
    k = 0;
    for (j = 0; j < TBL_JOBS; j++) begin
      job_cmd.push_back(tbl_cmd[j]);
      for (n = 0; n < int'(tbl_cmd[j].rows) * int'(tbl_cmd[j].cols); n++) begin
        // Hand values also vouch for the model
        check_value("root_ref", 32'(root_ref(tbl_elem[k], tbl_cmd[j].modulus)), 32'(tbl_exp[k]));
        elem_in.push_back(tbl_elem[k]);
        elem_exp.push_back(tbl_exp[k]);
        k++;
      end
    end
    // Random job, size 1 to 8 each way
    c.rows    = 4'(1 + lcg_next() % 8);
    c.cols    = 4'(1 + lcg_next() % 8);
    c.modulus = `MR_DATA_W'(lcg_next() % 50);
    job_cmd.push_back(c);
    for (n = 0; n < int'(c.rows) * int'(c.cols); n++) begin
      e.a = `MR_DATA_W'(lcg_next());
      e.b = `MR_EXP_W'(lcg_next());
      elem_in.push_back(e);
      elem_exp.push_back(root_ref(e, c.modulus));
    end
  endtask

  task automatic issue_start(mr_cmd_t c);
    @(posedge CLK);
    start <= 1'b1;
    cmd   <= c;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // Full four-phase cycle on the element port
  task automatic send_elem(mr_elem_t e);
    @(posedge CLK);
    elem_req <= 1'b1;
    elem     <= e;
    do @(posedge CLK); while (!elem_ack);
    elem_req <= 1'b0;
    do @(posedge CLK); while (elem_ack);
  endtask

  task automatic run_job(int j, int base);
    mr_cmd_t    c;
    mr_result_t expected;
    int         row_i;
    int         col_i;
    int         k;
    c = job_cmd[j];
    issue_start(c);
    @(posedge CLK);
    check_value("busy", 32'(busy), 32'd1);
    k = base;
    for (row_i = 0; row_i < int'(c.rows); row_i++) begin
      for (col_i = 0; col_i < int'(c.cols); col_i++) begin
        expected.value = elem_exp[k];
        expected.row   = `MR_IDX_W'(row_i);
        expected.col   = `MR_IDX_W'(col_i);
        expected.last  = (row_i == int'(c.rows) - 1) && (col_i == int'(c.cols) - 1);
        exp_q.push_back(expected);
        send_elem(elem_in[k]);
        // Second start mid-matrix, results must still follow c
        if (j == IGNORED_JOB && k == base) begin
          issue_start(IGNORED_CMD);
          check_value("busy", 32'(busy), 32'd1);
        end
        k++;
      end
    end
    // Busy falls together with the last ack
    check_value("busy", 32'(busy), 32'd0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int j;
    int base;
    RST      = 1'b1;
    start    = 1'b0;
    cmd      = '0;
    elem_req = 1'b0;
    elem     = '0;
    build_jobs();
    cycle_limit = elem_in.size() * 16 * 17 + 200;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    base = 0;
    for (j = 0; j < job_cmd.size(); j++) begin
      run_job(j, base);
      base += int'(job_cmd[j].rows) * int'(job_cmd[j].cols);
    end
    while (exp_q.size() != 0) @(posedge CLK);
    // Quiet window, any extra result would show here
    repeat (50) @(posedge CLK);
    if (i_dut.i_sva.assert_errors == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Handshake assertions failed during the run");
      stop_with_failure();
    end
  end

  // Result sink with random ack delay
  initial begin : sink
    mr_result_t got;
    mr_result_t expected;
    int         delay;
    res_ack = 1'b0;
    forever begin
      do @(posedge CLK); while (!res_req);
      got = res;
      if (exp_q.size() == 0) begin
        $display("Result at row %0d col %0d arrived with no element pending", got.row, got.col);
        stop_with_failure();
      end else begin
        expected = exp_q.pop_front();
        check_value("res.value", 32'(got.value), 32'(expected.value));
        check_value("res.row", 32'(got.row), 32'(expected.row));
        check_value("res.col", 32'(got.col), 32'(expected.col));
        check_value("res.last", 32'(got.last), 32'(expected.last));
      end
      delay = lcg_next() % 21;
      repeat (delay) @(posedge CLK);
      res_ack <= 1'b1;
      do @(posedge CLK); while (res_req);
      res_ack <= 1'b0;
    end
  end

  // Cycle limit and early stop on a protocol error
  initial begin : watchdog
    wait (cycle_limit != 0);
    forever begin
      @(posedge CLK);
      cycles++;
      if (cycles >= cycle_limit) begin
        $display("Timeout after %0d cycles with %0d results missing", cycles, exp_q.size());
        stop_with_failure();
      end else if (i_dut.i_sva.assert_errors != 0) begin
        $display("A handshake assertion failed, see the error above");
        stop_with_failure();
      end
    end
  end

endmodule

//--- project.f
+incdir+rtl
rtl/matrix_root_pkg.sv
rtl/element_sequencer.sv
rtl/job_fifo.sv
rtl/root_engine.sv
rtl/matrix_root_top.sv
tb/matrix_root_sva.sv
tb/matrix_root_tb.sv

//--- Bender.yml
package:
  name: matrix_root

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/matrix_root_pkg.sv
      - rtl/element_sequencer.sv
      - rtl/job_fifo.sv
      - rtl/root_engine.sv
      - rtl/matrix_root_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/matrix_root_sva.sv
      - tb/matrix_root_tb.sv
